// File: cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int XLEN = 32;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5  // Signed compare
    } aluOp_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_s;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_s;

    typedef struct packed {
        logic [6:0] immHi;  // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;  // imm[4:0]
        logic [6:0] opcode;
    } sType_s;

    // Branch offset bits as scattered by the ISA
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_s;

    typedef union packed {
        rType_s rType;
        iType_s iType;
        sType_s sType;
        bType_s bType;
    } instWord_u;

    typedef struct packed {
        logic            regWrite;
        logic            memWrite;
        logic            memToReg;
        logic            aluSrcImm;
        logic            isBranch;
        logic            branchOnNotEqual;
        aluOp_e          aluOp;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] imm;  // Already sign extended
    } ctrl_s;

    // One record per retired instruction
    typedef struct packed {
        logic            wbEn;
        logic [4:0]      rd;
        logic [XLEN-1:0] wbData;
        logic [XLEN-1:0] pc;
    } retire_s;

endpackage

`default_nettype wire

// File: pcUnit.sv
`timescale 1ns/10ps
`default_nettype none

module pcUnit import cpuPkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            CLK,
    input  logic            rstN,
    input  logic            branchTaken,
    input  logic [XLEN-1:0] branchTarget,
    output logic [XLEN-1:0] pc
);

    logic [XLEN-1:0] pcNext;

    // Sequential fetch unless a branch resolves taken
    assign pcNext = branchTaken ? branchTarget : pc + XLEN'(4);

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    // Branch offsets come from the decoder, so a bad target shows up here
    pcAligned: assert property (
        @(posedge CLK) disable iff (!rstN)
        pc[1:0] == 2'b00
    ) else $error("pc 0x%08h is not word aligned", pc);

endmodule

`default_nettype wire

// File: decodeUnit.sv
`timescale 1ns/10ps
`default_nettype none

module decodeUnit import cpuPkg::*; (
    input  logic      rstN,
    input  instWord_u inst,
    output ctrl_s     ctrl
);

    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    aluOp_e          rAluOp;
    aluOp_e          iAluOp;
    logic            rLegal;
    logic            iLegal;

    assign funct3 = inst.rType.funct3;
    assign funct7 = inst.rType.funct7;

    assign immI = {{20{inst.iType.imm[11]}}, inst.iType.imm};
    assign immS = {{20{inst.sType.immHi[6]}}, inst.sType.immHi, inst.sType.immLo};
    assign immB = {{19{inst.bType.imm12}}, inst.bType.imm12, inst.bType.imm11,
                   inst.bType.imm10to5, inst.bType.imm4to1, 1'b0};  // Bit 0 always zero

    // Register-register ops
    always_comb begin
        rAluOp = ALU_ADD;
        rLegal = 1'b1;
        case ({funct7, funct3})
            {7'h00, 3'b000}: rAluOp = ALU_ADD;
            {7'h20, 3'b000}: rAluOp = ALU_SUB;
            {7'h00, 3'b111}: rAluOp = ALU_AND;
            {7'h00, 3'b110}: rAluOp = ALU_OR;
            {7'h00, 3'b100}: rAluOp = ALU_XOR;
            {7'h00, 3'b010}: rAluOp = ALU_SLT;
            default:         rLegal = 1'b0;
        endcase
    end

    // Immediate ops with funct7 inside the immediate
    always_comb begin
        iAluOp = ALU_ADD;
        iLegal = 1'b1;
        case (funct3)
            3'b000:  iAluOp = ALU_ADD;
            3'b111:  iAluOp = ALU_AND;
            3'b110:  iAluOp = ALU_OR;
            3'b100:  iAluOp = ALU_XOR;
            3'b010:  iAluOp = ALU_SLT;
            default: iLegal = 1'b0;
        endcase
    end

    always_comb begin
        ctrl     = '0;  // Anything unmatched stays a no-op
        ctrl.rd  = inst.rType.rd;
        ctrl.rs1 = inst.rType.rs1;
        ctrl.rs2 = inst.rType.rs2;
        case (inst.rType.opcode)
            OPC_OP: begin
                ctrl.regWrite = rLegal;
                ctrl.aluOp    = rAluOp;
            end
            OPC_OP_IMM: begin
                ctrl.regWrite  = iLegal;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = iAluOp;
                ctrl.imm       = immI;
            end
            OPC_LOAD: begin
                ctrl.regWrite  = (funct3 == 3'b010);  // lw only
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm       = immI;
            end
            OPC_STORE: begin
                ctrl.memWrite  = (funct3 == 3'b010);  // sw only
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm       = immS;
            end
            OPC_BRANCH: begin
                ctrl.isBranch         = (funct3 == 3'b000) || (funct3 == 3'b001);
                ctrl.branchOnNotEqual = funct3[0];
                ctrl.aluOp            = ALU_SUB;
                ctrl.imm              = immB;
            end
            default: ;
        endcase

        // Nothing may change state while held in reset
        if (!rstN) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
            ctrl.isBranch = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile import cpuPkg::*; (
    input  logic            CLK,
    input  logic            rstN,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic            wbEn,
    input  logic [XLEN-1:0] wbData,
    output logic [XLEN-1:0] rs1Data,
    output logic [XLEN-1:0] rs2Data
);

    logic [XLEN-1:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (rd != 5'd0)) begin
            regs[rd] <= wbData;
        end
    end

    // Combinational reads
    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: execUnit.sv
`timescale 1ns/10ps
`default_nettype none

module execUnit import cpuPkg::*; (
    input  ctrl_s           ctrl,
    input  logic [XLEN-1:0] rs1Data,
    input  logic [XLEN-1:0] rs2Data,
    input  logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] aluResult,
    output logic            branchTaken,
    output logic [XLEN-1:0] branchTarget
);

    logic [XLEN-1:0] opB;
    logic            operandsEqual;

    assign opB = ctrl.aluSrcImm ? ctrl.imm : rs2Data;

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: aluResult = rs1Data + opB;  // Also address for lw and sw
            ALU_SUB: aluResult = rs1Data - opB;
            ALU_AND: aluResult = rs1Data & opB;
            ALU_OR:  aluResult = rs1Data | opB;
            ALU_XOR: aluResult = rs1Data ^ opB;
            ALU_SLT: aluResult = XLEN'($signed(rs1Data) < $signed(opB));
            default: aluResult = '0;
        endcase
    end

    // beq takes on equal, bne on not equal
    assign operandsEqual = (rs1Data == rs2Data);
    assign branchTaken   = ctrl.isBranch && (operandsEqual ^ ctrl.branchOnNotEqual);
    assign branchTarget  = pc + ctrl.imm;

endmodule

`default_nettype wire

// File: dataMem.sv
`timescale 1ns/10ps
`default_nettype none

module dataMem import cpuPkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic            CLK,
    input  logic            rstN,
    input  logic [XLEN-1:0] addr,
    input  logic            memWrite,
    input  logic [XLEN-1:0] storeData,
    output logic [XLEN-1:0] loadData
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] mem [DMEM_WORDS];
    logic [AW-1:0]   wordAddr;

    assign wordAddr = addr[AW+1:2];  // Upper bits ignored, so addresses wrap

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (memWrite) begin
            mem[wordAddr] <= storeData;
        end
    end

    assign loadData = mem[wordAddr];

    storeAligned: assert property (
        @(posedge CLK) disable iff (!rstN)
        memWrite |-> (addr[1:0] == 2'b00)
    ) else $error("Unaligned store to 0x%08h", addr);

endmodule

`default_nettype wire

// File: resultUnit.sv
`timescale 1ns/10ps
`default_nettype none

module resultUnit import cpuPkg::*; (
    input  ctrl_s           ctrl,
    input  logic [XLEN-1:0] aluResult,
    input  logic [XLEN-1:0] loadData,
    input  logic [XLEN-1:0] pc,
    output logic            wbEn,
    output logic [4:0]      rd,
    output logic [XLEN-1:0] wbData,
    output retire_s         retire
);

    assign wbEn   = ctrl.regWrite && (ctrl.rd != 5'd0);  // Writes to x0 show as none
    assign rd     = ctrl.rd;
    assign wbData = ctrl.memToReg ? loadData : aluResult;

    always_comb begin
        retire.wbEn   = wbEn;
        retire.rd     = rd;
        retire.wbData = wbData;
        retire.pc     = pc;
    end

endmodule

`default_nettype wire

// File: singleCpu.sv
`timescale 1ns/10ps
`default_nettype none

module singleCpu import cpuPkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC   = '0,
    parameter int              DMEM_WORDS = 256
) (
    input  logic            CLK,
    input  logic            rstN,
    output logic [XLEN-1:0] instAddr,  // Doubles as the current pc
    input  instWord_u       inst,
    output retire_s         retire
);

    ctrl_s           ctrl;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] aluResult;
    logic            branchTaken;
    logic [XLEN-1:0] branchTarget;
    logic [XLEN-1:0] loadData;

    // Write-back path
    logic            wbEn;
    logic [4:0]      wbRd;
    logic [XLEN-1:0] wbData;

    pcUnit #(
        .RESET_PC(RESET_PC)
    ) pcUnit_i (
        .CLK(CLK),
        .rstN(rstN),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .pc(instAddr)
    );

    decodeUnit decodeUnit_i (
        .rstN(rstN),
        .inst(inst),
        .ctrl(ctrl)
    );

    regFile regFile_i (
        .CLK(CLK),
        .rstN(rstN),
        .rs1(ctrl.rs1),
        .rs2(ctrl.rs2),
        .rd(wbRd),
        .wbEn(wbEn),
        .wbData(wbData),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    execUnit execUnit_i (
        .ctrl(ctrl),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .pc(instAddr),
        .aluResult(aluResult),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    dataMem #(
        .DMEM_WORDS(DMEM_WORDS)
    ) dataMem_i (
        .CLK(CLK),
        .rstN(rstN),
        .addr(aluResult),
        .memWrite(ctrl.memWrite),
        .storeData(rs2Data),
        .loadData(loadData)
    );

    resultUnit resultUnit_i (
        .ctrl(ctrl),
        .aluResult(aluResult),
        .loadData(loadData),
        .pc(instAddr),
        .wbEn(wbEn),
        .rd(wbRd),
        .wbData(wbData),
        .retire(retire)
    );

endmodule

`default_nettype wire

// File: singleCpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module singleCpu_tb import cpuPkg::*; ();

    localparam int              CLK_PERIOD   = 100;
    localparam int              RESET_CYCLES = 8;
    localparam int              PROG_WORDS   = 64;
    localparam logic [XLEN-1:0] RESET_PC     = '0;

    logic            CLK;
    logic            rstN;
    logic [XLEN-1:0] instAddr;
    instWord_u       inst;
    retire_s         retire;

    logic [XLEN-1:0] progMem [PROG_WORDS];
    retire_s         expected [$];
    int              numRecords;
    logic            loaded;

    singleCpu #(
        .RESET_PC(RESET_PC),
        .DMEM_WORDS(256)
    ) singleCpu_i (
        .CLK(CLK),
        .rstN(rstN),
        .instAddr(instAddr),
        .inst(inst),
        .retire(retire)
    );

    // Instruction memory answers in the same cycle
    assign inst = (instAddr[XLEN-1:2] < PROG_WORDS) ? progMem[instAddr[XLEN-1:2]] : '0;

    initial CLK = 1'b0;
    always #(CLK_PERIOD / 2) CLK = ~CLK;

    task automatic loadPatterns();
        int                fd;
        int                code;
        int                wordCount;
        logic [8*8-1:0]    tag;
        logic [8*160-1:0]  line;
        logic [XLEN-1:0]   word;
        logic [XLEN-1:0]   pcVal;
        logic [XLEN-1:0]   dataVal;
        logic [4:0]        rdVal;
        logic              wbEnVal;
        retire_s           rec;
        wordCount = 0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            progMem[i] = {i[24:0], 7'b0000000};  // Opcode 0, retires as a no-op
        end
        fd = $fopen("singleCpu_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file singleCpu_patterns.txt");
            $display("Test failed");
            $fatal(1, "Missing stimulus");
        end else begin
            while (!$feof(fd)) begin
                tag  = '0;
                code = $fscanf(fd, "%s", tag);
                if (code == 1) begin
                    if (tag == "P" && wordCount < PROG_WORDS) begin
                        code = $fscanf(fd, "%h", word);
                        progMem[wordCount] = word;
                        wordCount++;
                    end else if (tag == "E") begin
                        code = $fscanf(fd, "%h %h %h %h", pcVal, wbEnVal, rdVal, dataVal);
                        rec.pc     = pcVal;
                        rec.wbEn   = wbEnVal;
                        rec.rd     = rdVal;
                        rec.wbData = dataVal;
                        expected.push_back(rec);
                    end else begin
                        code = $fgets(line, fd);  // Comment, skip the rest of the line
                    end
                end
            end
            $fclose(fd);
        end
        numRecords = expected.size();
        $display("Loaded %0d program words and %0d retire records", wordCount, numRecords);
    endtask

    task automatic compareField(input string label, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s is 0x%08h, expected 0x%08h", $time, label, got, exp);
            $display("Test failed");
            $fatal(1, "Retire mismatch");
        end
    endtask

    task automatic checkRecord(input int index);
        retire_s rec;
        rec = expected[index];
        compareField($sformatf("record %0d pc", index), retire.pc, rec.pc);
        compareField($sformatf("record %0d wbEn", index), retire.wbEn, rec.wbEn);
        if (rec.wbEn) begin  // rd and data only mean something on a write
            compareField($sformatf("record %0d rd", index), retire.rd, rec.rd);
            compareField($sformatf("record %0d wbData", index), retire.wbData, rec.wbData);
        end
    endtask

    initial begin
        rstN   = 1'b0;
        loaded = 1'b0;
        loadPatterns();
        loaded = 1'b1;

        // Core must sit at the reset address with no write
        repeat (RESET_CYCLES) begin
            @(negedge CLK);
            compareField("reset instAddr", instAddr, RESET_PC);
            compareField("reset wbEn", retire.wbEn, 1'b0);
        end
        @(posedge CLK);
        rstN <= 1'b1;

        // Retire outputs are settled by the falling edge
        for (int k = 0; k < numRecords; k++) begin
            @(negedge CLK);
            checkRecord(k);
        end

        $display("Test completed successfully");
        $finish;
    end

    initial begin
        wait (loaded);
        #((RESET_CYCLES + numRecords + 10) * CLK_PERIOD);
        $display("Watchdog expired, the program did not finish in time");
        $display("Test failed");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

// File: singleCpu_patterns.txt
# P <word>  instruction words, stored from address 0 upward
# E <pc> <wbEn> <rd> <wbData>  one retire record per cycle after reset, rd and wbData ignored when wbEn is 0
P 00500093 # addi x1, x0, 5
P FFD00113 # addi x2, x0, -3
P 002081B3 # add  x3, x1, x2
P 40208233 # sub  x4, x1, x2
P 0020F2B3 # and  x5, x1, x2
P 0020E333 # or   x6, x1, x2
P 0020C3B3 # xor  x7, x1, x2
P 00112433 # slt  x8, x2, x1
P FFE12493 # slti x9, x2, -2
P 0F017513 # andi x10, x2, 0x0f0
P FF00E593 # ori  x11, x1, -16
P 7FF0C613 # xori x12, x1, 0x7ff
P 00702823 # sw   x7, 16(x0)
P 01002683 # lw   x13, 16(x0)
P 01402703 # lw   x14, 20(x0)
P 00208463 # beq  x1, x2, +8
P 00209463 # bne  x1, x2, +8
P 00100793 # addi x15, x0, 1
P 00319463 # bne  x3, x3, +8
P 00708013 # addi x0, x1, 7
P 00100833 # add  x16, x0, x1
P 000018B7 # lui  x17, 1
P 00000663 # beq  x0, x0, +12
P 05500913 # addi x18, x0, 0x55
P 00000463 # beq  x0, x0, +8
P FE000CE3 # beq  x0, x0, -8
E 00000000 1 01 00000005
E 00000004 1 02 FFFFFFFD
E 00000008 1 03 00000002
E 0000000C 1 04 00000008
E 00000010 1 05 00000005
E 00000014 1 06 FFFFFFFD
E 00000018 1 07 FFFFFFF8
E 0000001C 1 08 00000001
E 00000020 1 09 00000001
E 00000024 1 0A 000000F0
E 00000028 1 0B FFFFFFF5
E 0000002C 1 0C 000007FA
E 00000030 0 00 00000000
E 00000034 1 0D FFFFFFF8
E 00000038 1 0E 00000000
E 0000003C 0 00 00000000
E 00000040 0 00 00000000
E 00000048 0 00 00000000
E 0000004C 0 00 00000000
E 00000050 1 10 00000005
E 00000054 0 00 00000000
E 00000058 0 00 00000000
E 00000064 0 00 00000000
E 0000005C 1 12 00000055
E 00000060 0 00 00000000
E 00000068 0 00 00000000

// File: singleCpu.f
cpuPkg.sv
pcUnit.sv
decodeUnit.sv
regFile.sv
execUnit.sv
dataMem.sv
resultUnit.sv
singleCpu.sv
singleCpu_tb.sv

// File: Bender.yml
package:
  name: singleCpu

sources:
  - cpuPkg.sv
  - pcUnit.sv
  - decodeUnit.sv
  - regFile.sv
  - execUnit.sv
  - dataMem.sv
  - resultUnit.sv
  - singleCpu.sv
  - target: test
    files:
      - singleCpu_tb.sv
